// ==== common/mem_wr_pkg.sv ====
// write-side bus widths and request bundle for all controller and memory ports.
// memory address space is fixed at 2**ADDR_WID words.
`default_nettype none

package mem_wr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word address, 256 words.
    localparam int ADDR_WID = 8;

    // write data.
    localparam int DATA_WID = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // en is a level asking for access, req is the write strobe.
    // a write goes through on a clock edge where en, req and rdy are all high.
    typedef struct packed {
        logic                en;
        logic                req;
        logic [ADDR_WID-1:0] addr;
        logic [DATA_WID-1:0] data;
    } mem_wr_req_t;

endpackage : mem_wr_pkg

`default_nettype wire

// ==== common/mem_wr_arb_pkg.sv ====
// arbiter FSM encoding, shared with the bound properties.
`default_nettype none

package mem_wr_arb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbiter states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // idle: nobody selected.
    // grant: one controller owns the mux.
    // next: one-cycle handover before the next grant.
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_GRANT = 2'd1,
        ARB_NEXT  = 2'd2
    } arb_state_t;

endpackage : mem_wr_arb_pkg

`default_nettype wire

// ==== mem_wr_mux/mem_wr_ctxt_fifo.sv ====
// small FIFO, head visible combinationally; pushes while full and pops while empty are dropped.
// DEPTH need not be a power of two.
`default_nettype none

module mem_wr_ctxt_fifo #(
    parameter int DATA_WID = 2,
    parameter int DEPTH    = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_rdy,
    input  logic                rd,
    output logic [DATA_WID-1:0] rd_data,
    output logic                rd_vld
);
    localparam int PTR_WID = DEPTH > 1 ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [PTR_WID-1:0]  wr_ptr;
    logic [PTR_WID-1:0]  rd_ptr;
    logic [CNT_WID-1:0]  count;
    logic                push;
    logic                pop;

    assign wr_rdy  = count < CNT_WID'(DEPTH);
    assign rd_vld  = count != '0;
    assign rd_data = mem[rd_ptr];

    assign push = wr && wr_rdy;
    assign pop  = rd && rd_vld;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at DEPTH.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : mem_wr_ctxt_fifo

`default_nettype wire

// ==== mem_wr_mux/mem_wr_mux.sv ====
// routes the granted controller to the memory; acks are steered back via a context FIFO.
// at most NUM_TRANSACTIONS writes may be waiting for an ack.
`default_nettype none

module mem_wr_mux #(
    parameter int N                = 3,
    parameter int NUM_TRANSACTIONS = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_wr_pkg::mem_wr_req_t  ctrl_req [N],
    output logic [N-1:0]             ctrl_rdy,
    output logic [N-1:0]             ctrl_ack,
    input  logic [(N > 1 ? $clog2(N) : 1)-1:0] sel,
    input  logic                     grant_vld,
    output logic                     accept,
    output mem_wr_pkg::mem_wr_req_t  mem_req,
    input  logic                     mem_rdy,
    input  logic                     mem_ack
);
    import mem_wr_pkg::*;

    localparam int SEL_WID = N > 1 ? $clog2(N) : 1;

    mem_wr_req_t        sel_req;
    logic               path_open;
    logic               fifo_wr_rdy;
    logic [SEL_WID-1:0] ack_sel;
    logic               ack_sel_vld;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        sel_req = '0;
        for (int i = 0; i < N; i++) begin
            if (sel == SEL_WID'(i)) begin
                sel_req = ctrl_req[i];
            end
        end
    end

    // no grant or no room for context, nothing reaches the memory.
    assign path_open = grant_vld && fifo_wr_rdy;

    always_comb begin
        mem_req     = sel_req;
        mem_req.en  = sel_req.en && path_open;
        mem_req.req = sel_req.req && path_open;
    end

    assign accept = mem_req.en && mem_req.req && mem_rdy;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ctrl_rdy[i] = (sel == SEL_WID'(i)) && path_open && mem_rdy;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // context and ack return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_wr_ctxt_fifo #(
        .DATA_WID ( SEL_WID ),
        .DEPTH    ( NUM_TRANSACTIONS )
    ) ctxt_fifo_i (
        .clk     ( clk ),
        .reset   ( reset ),
        .wr      ( accept ),
        .wr_data ( sel ),
        .wr_rdy  ( fifo_wr_rdy ),
        .rd      ( mem_ack ),
        .rd_data ( ack_sel ),
        .rd_vld  ( ack_sel_vld )
    );

    // head of the FIFO names the source of the oldest write.
    always_comb begin
        for (int i = 0; i < N; i++) begin
            ctrl_ack[i] = mem_ack && ack_sel_vld && (ack_sel == SEL_WID'(i));
        end
    end

endmodule : mem_wr_mux

`default_nettype wire

// ==== verilog/mem_wr_arbiter.sv ====
// round-robin grant FSM; a controller switch costs two idle cycles.
// grant is held until en drops or the burst counter says stop.
`default_nettype none

module mem_wr_arbiter #(
    parameter int N = 3
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [N-1:0]                       en_vec,
    input  logic                               burst_done,
    output logic [(N > 1 ? $clog2(N) : 1)-1:0] sel,
    output logic                               grant_vld,
    output logic                               grant_start
);
    import mem_wr_arb_pkg::*;

    localparam int SEL_WID = N > 1 ? $clog2(N) : 1;

    arb_state_t state;
    logic       release_grant;

    // nearest enabled controller after cur, cur itself last.
    function automatic logic [SEL_WID-1:0] next_sel(
        input logic [N-1:0]       en,
        input logic [SEL_WID-1:0] cur
    );
        int                 idx;
        logic [SEL_WID-1:0] pick;
        pick = cur;
        for (int i = N; i >= 1; i--) begin
            idx = (int'(cur) + i) % N;
            if (en[idx]) begin
                pick = SEL_WID'(idx);
            end
        end
        return pick;
    endfunction

    // burst_done is stale from the old grant during the grant_start cycle.
    assign release_grant = !en_vec[sel] || (burst_done && !grant_start);

    assign grant_vld = (state == ARB_GRANT) && (grant_start || !burst_done);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ARB_IDLE;
            sel         <= '0;
            grant_start <= 1'b0;
        end else begin
            grant_start <= 1'b0;
            case (state)
                ARB_IDLE, ARB_NEXT: begin
                    if (|en_vec) begin
                        state       <= ARB_GRANT;
                        sel         <= next_sel(en_vec, sel);
                        grant_start <= 1'b1;
                    end else begin
                        state <= ARB_IDLE;
                    end
                end
                ARB_GRANT: begin
                    if (release_grant) begin
                        state <= ARB_NEXT;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule : mem_wr_arbiter

`default_nettype wire

// ==== verilog/burst_counter.sv ====
// counts accepts in the current grant, saturating at BURST_LEN.
`default_nettype none

module burst_counter #(
    parameter int BURST_LEN = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic grant_start,
    input  logic accept,
    output logic burst_done
);
    localparam int CNT_WID = $clog2(BURST_LEN + 1);

    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] count_nxt;

    // an accept in the grant_start cycle is the first of the new burst.
    always_comb begin
        count_nxt = grant_start ? '0 : count;
        if (accept && (count_nxt < CNT_WID'(BURST_LEN))) begin
            count_nxt = count_nxt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            burst_done <= 1'b0;
        end else begin
            count      <= count_nxt;
            burst_done <= count_nxt == CNT_WID'(BURST_LEN);
        end
    end

endmodule : burst_counter

`default_nettype wire

// ==== verilog/mem_wr_ram.sv ====
// write-only memory model, acks exactly ACK_LATENCY cycles after accept (ACK_LATENCY >= 1).
// read port is for checking only, one cycle latency.
`default_nettype none

module mem_wr_ram #(
    parameter int ACK_LATENCY = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stall,
    input  mem_wr_pkg::mem_wr_req_t         mem_req,
    output logic                            mem_rdy,
    output logic                            mem_ack,
    input  logic [mem_wr_pkg::ADDR_WID-1:0] rd_addr,
    output logic [mem_wr_pkg::DATA_WID-1:0] rd_data
);
    import mem_wr_pkg::*;

    logic [DATA_WID-1:0]    mem [2**ADDR_WID];
    logic [ACK_LATENCY-1:0] ack_pipe;
    logic                   accept;

    assign mem_rdy = !stall;
    assign accept  = mem_req.en && mem_req.req && mem_rdy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[mem_req.addr] <= mem_req.data;
        end
        rd_data <= mem[rd_addr];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ack delay line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one bit per stage, so back-to-back writes overlap.
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe[0] <= accept;
            for (int i = 1; i < ACK_LATENCY; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

    assign mem_ack = ack_pipe[ACK_LATENCY-1];

endmodule : mem_wr_ram

`default_nettype wire

// ==== verilog/mem_wr_subsys.sv ====
// N write controllers sharing one memory through a round-robin mux.
// rd_addr/rd_data bypass arbitration and are meant for checking.
`default_nettype none

module mem_wr_subsys #(
    parameter int N                = 3,
    parameter int NUM_TRANSACTIONS = 8,
    parameter int BURST_LEN        = 4,
    parameter int ACK_LATENCY      = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  mem_wr_pkg::mem_wr_req_t         ctrl_req [N],
    output logic [N-1:0]                    ctrl_rdy,
    output logic [N-1:0]                    ctrl_ack,
    input  logic                            stall,
    input  logic [mem_wr_pkg::ADDR_WID-1:0] rd_addr,
    output logic [mem_wr_pkg::DATA_WID-1:0] rd_data
);
    import mem_wr_pkg::*;

    localparam int SEL_WID = N > 1 ? $clog2(N) : 1;

    logic [N-1:0]       en_vec;
    logic [SEL_WID-1:0] sel;
    logic               grant_vld;
    logic               grant_start;
    logic               burst_done;
    logic               accept;
    mem_wr_req_t        mem_req;
    logic               mem_rdy;
    logic               mem_ack;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            en_vec[i] = ctrl_req[i].en;
        end
    end

    mem_wr_arbiter #(
        .N ( N )
    ) mem_wr_arbiter_i (
        .clk         ( clk ),
        .reset       ( reset ),
        .en_vec      ( en_vec ),
        .burst_done  ( burst_done ),
        .sel         ( sel ),
        .grant_vld   ( grant_vld ),
        .grant_start ( grant_start )
    );

    burst_counter #(
        .BURST_LEN ( BURST_LEN )
    ) burst_counter_i (
        .clk         ( clk ),
        .reset       ( reset ),
        .grant_start ( grant_start ),
        .accept      ( accept ),
        .burst_done  ( burst_done )
    );

    mem_wr_mux #(
        .N                ( N ),
        .NUM_TRANSACTIONS ( NUM_TRANSACTIONS )
    ) mem_wr_mux_i (
        .clk       ( clk ),
        .reset     ( reset ),
        .ctrl_req  ( ctrl_req ),
        .ctrl_rdy  ( ctrl_rdy ),
        .ctrl_ack  ( ctrl_ack ),
        .sel       ( sel ),
        .grant_vld ( grant_vld ),
        .accept    ( accept ),
        .mem_req   ( mem_req ),
        .mem_rdy   ( mem_rdy ),
        .mem_ack   ( mem_ack )
    );

    mem_wr_ram #(
        .ACK_LATENCY ( ACK_LATENCY )
    ) mem_wr_ram_i (
        .clk     ( clk ),
        .reset   ( reset ),
        .stall   ( stall ),
        .mem_req ( mem_req ),
        .mem_rdy ( mem_rdy ),
        .mem_ack ( mem_ack ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

endmodule : mem_wr_subsys

`default_nettype wire

// ==== testbench/mem_wr_subsys_properties.sv ====
// bound into both the arbiter and the mux; ports a target lacks are tied off at the bind.
`default_nettype none

module mem_wr_subsys_properties #(
    parameter int N = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  mem_wr_arb_pkg::arb_state_t state,
    input  logic                       grant_start,
    input  logic [N-1:0]               ctrl_rdy,
    input  logic                       accept,
    input  logic                       mem_rdy
);
    import mem_wr_arb_pkg::*;

    // only the granted controller may see rdy.
    rdy_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ctrl_rdy))
        else $error("more than one ctrl_rdy high");

    // stall forces mem_rdy low.
    no_accept_in_stall: assert property (@(posedge clk) disable iff (reset)
        accept |-> mem_rdy)
        else $error("write accepted while the memory is stalled");

    next_leaves_cleanly: assert property (@(posedge clk) disable iff (reset)
        state == ARB_NEXT |=> (state == ARB_GRANT && grant_start) || state == ARB_IDLE)
        else $error("arbiter left the handover state without a new grant or idle");

endmodule : mem_wr_subsys_properties

bind mem_wr_arbiter mem_wr_subsys_properties #(.N(N)) arb_props_i (
    .clk         ( clk ),
    .reset       ( reset ),
    .state       ( state ),
    .grant_start ( grant_start ),
    .ctrl_rdy    ( '0 ),
    .accept      ( 1'b0 ),
    .mem_rdy     ( 1'b1 )
);

bind mem_wr_mux mem_wr_subsys_properties #(.N(N)) mux_props_i (
    .clk         ( clk ),
    .reset       ( reset ),
    .state       ( mem_wr_arb_pkg::ARB_IDLE ),
    .grant_start ( 1'b0 ),
    .ctrl_rdy    ( ctrl_rdy ),
    .accept      ( accept ),
    .mem_rdy     ( mem_rdy )
);

`default_nettype wire

// ==== testbench/mem_wr_subsys_tb.sv ====
// stimulus and expected memory words come from testbench/mem_wr_golden.txt.
// run from the project root; controllers must use disjoint address ranges.
`default_nettype none

module mem_wr_subsys_tb;
    import mem_wr_pkg::*;

    localparam int N                = 3;
    localparam int NUM_TRANSACTIONS = 2;
    localparam int BURST_LEN        = 4;
    localparam int ACK_LATENCY      = 6;
    localparam int GOLD_WORDS       = 160;

    localparam int T_RESET    = 0;
    localparam int T_ACK      = 1;
    localparam int T_DATA     = 2;
    localparam int T_STALL    = 3;
    localparam int T_FAIR     = 4;
    localparam int T_INFLIGHT = 5;

    logic                clk;
    logic                reset;
    mem_wr_req_t         ctrl_req [N];
    logic [N-1:0]        ctrl_rdy;
    logic [N-1:0]        ctrl_ack;
    logic                stall;
    logic [ADDR_WID-1:0] rd_addr;
    logic [DATA_WID-1:0] rd_data;

    logic [31:0]   gold [GOLD_WORDS];
    logic [39:0]   wr_q [N][$];
    logic [7:0]    exp_addr [$];
    logic [31:0]   exp_data [$];
    int            stall_start [$];
    int            stall_len [$];
    bit            golden_loaded;

    int cyc;
    int ack_due [N][$];
    int accepts [N];
    int acks [N];
    int passed_over [N];
    int inflight;
    int run_len;
    int last_acc;
    int errs [6];
    int n_checks;
    int drivers_done;

    mem_wr_subsys #(
        .N                ( N ),
        .NUM_TRANSACTIONS ( NUM_TRANSACTIONS ),
        .BURST_LEN        ( BURST_LEN ),
        .ACK_LATENCY      ( ACK_LATENCY )
    ) mem_wr_subsys_i (
        .clk      ( clk ),
        .reset    ( reset ),
        .ctrl_req ( ctrl_req ),
        .ctrl_rdy ( ctrl_rdy ),
        .ctrl_ack ( ctrl_ack ),
        .stall    ( stall ),
        .rd_addr  ( rd_addr ),
        .rd_data  ( rd_data )
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check_eq(input int test, input string name,
                            input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h exp 0x%0h (cycle %0d)", name, got, exp, cyc);
            errs[test]++;
        end
    endtask

    task automatic note_failure(input int test, input string msg);
        $display("ERROR at cycle %0d: %s", cyc, msg);
        errs[test]++;
    endtask

    function automatic string test_label(input int test);
        case (test)
            T_RESET:  return "reset";
            T_ACK:    return "ack latency";
            T_DATA:   return "memory data";
            T_STALL:  return "stall";
            T_FAIR:   return "fairness";
            default:  return "in-flight limit";
        endcase
    endfunction

    task automatic report_test(input int test);
        if (errs[test] == 0) begin
            $display("test %-16s passed", test_label(test));
        end else begin
            $display("test %-16s failed, %0d errors", test_label(test), errs[test]);
        end
    endtask

    function automatic bit in_stall_window(input int t);
        for (int i = 0; i < stall_start.size(); i++) begin
            if (t >= stall_start[i] && t < stall_start[i] + stall_len[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // one write at a time; en held until rdy is seen at an edge.
    task automatic drive_writes(input int c);
        mem_wr_req_t r;
        int          gap;
        int          drop;
        @(posedge clk);
        while (reset) @(posedge clk);
        for (int w = 0; w < wr_q[c].size(); w++) begin
            r = '0;
            r.en = 1'b1;
            r.req = 1'b1;
            r.addr = wr_q[c][w][39:32];
            r.data = wr_q[c][w][31:0];
            ctrl_req[c] <= r;
            @(posedge clk);
            while (!ctrl_rdy[c]) @(posedge clk);
            gap = $urandom_range(3, 0);
            drop = $urandom_range(1, 0);
            if (gap > 0) begin
                r.req = 1'b0;
                r.en = (drop == 0);
                ctrl_req[c] <= r;
                repeat (gap) @(posedge clk);
            end
        end
        ctrl_req[c] <= '0;
        drivers_done++;
    endtask

    for (genvar g = 0; g < N; g++) begin : drivers
        initial drive_writes(g);
    end

    // cycle 0 is the first edge after reset release.
    always @(posedge clk) begin
        if (reset) begin
            cyc <= 0;
            stall <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            stall <= in_stall_window(cyc + 1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin : monitor
        logic [N-1:0] en_now;
        logic [N-1:0] acc;
        int           due;
        if (reset) begin
            inflight = 0;
            run_len = 0;
            last_acc = -1;
            for (int c = 0; c < N; c++) begin
                ack_due[c].delete();
            end
        end else begin
            for (int c = 0; c < N; c++) begin
                en_now[c] = ctrl_req[c].en;
                acc[c] = ctrl_req[c].en && ctrl_req[c].req && ctrl_rdy[c];
                if (!en_now[c]) begin
                    passed_over[c] = 0;
                end
            end
            for (int c = 0; c < N; c++) begin
                if (ctrl_ack[c]) begin
                    if (ack_due[c].size() == 0) begin
                        note_failure(T_ACK, $sformatf("ack on controller %0d with no write", c));
                    end else begin
                        due = ack_due[c].pop_front();
                        check_eq(T_ACK, $sformatf("ctrl_ack[%0d] cycle", c), 64'(cyc), 64'(due));
                        acks[c]++;
                        inflight--;
                    end
                end else if (ack_due[c].size() != 0 && ack_due[c][0] <= cyc) begin
                    note_failure(T_ACK, $sformatf("ack for controller %0d never came", c));
                    due = ack_due[c].pop_front();
                    inflight--;
                end
            end
            // same controller may be granted again when nobody else wants in.
            if (last_acc >= 0 && (en_now & ~(N'(1) << last_acc)) == '0) begin
                run_len = 0;
            end
            for (int c = 0; c < N; c++) begin
                if (acc[c]) begin
                    if (stall) begin
                        note_failure(T_STALL, $sformatf("controller %0d accepted in stall", c));
                    end
                    ack_due[c].push_back(cyc + ACK_LATENCY);
                    accepts[c]++;
                    inflight++;
                    if (c != last_acc) begin
                        for (int w = 0; w < N; w++) begin
                            if (w != c && en_now[w]) begin
                                passed_over[w]++;
                            end
                        end
                        run_len = 1;
                    end else begin
                        run_len++;
                    end
                    passed_over[c] = 0;
                    last_acc = c;
                    if (run_len > BURST_LEN) begin
                        note_failure(T_FAIR, $sformatf("controller %0d kept the grant too long", c));
                    end
                end
            end
            for (int w = 0; w < N; w++) begin
                if (passed_over[w] > N - 1) begin
                    note_failure(T_FAIR, $sformatf("controller %0d skipped in round robin", w));
                    passed_over[w] = 0;
                end
            end
            if (inflight > NUM_TRANSACTIONS) begin
                note_failure(T_INFLIGHT, $sformatf("%0d writes waiting for an ack", inflight));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : watchdog
        int limit;
        int n_writes;
        int n_stall;
        wait (golden_loaded);
        n_writes = 0;
        n_stall = 0;
        for (int c = 0; c < N; c++) begin
            n_writes += wr_q[c].size();
        end
        for (int i = 0; i < stall_len.size(); i++) begin
            n_stall += stall_len[i];
        end
        limit = n_writes * (ACK_LATENCY + N * BURST_LEN + 2) + n_stall + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        int ctrl_idx;
        int total_errs;
        int total_acc;
        reset <= 1'b1;
        stall <= 1'b0;
        rd_addr <= '0;
        for (int c = 0; c < N; c++) begin
            ctrl_req[c] <= '0;
        end
        void'($urandom(44213));
        for (int i = 0; i < GOLD_WORDS; i++) begin
            gold[i] = '0;
        end
        $readmemh("testbench/mem_wr_golden.txt", gold);
        for (int i = 0; i + 3 < GOLD_WORDS; i += 4) begin
            ctrl_idx = gold[i+1];
            case (gold[i])
                1: wr_q[ctrl_idx].push_back({gold[i+2][7:0], gold[i+3]});
                2: begin
                    stall_start.push_back(gold[i+1]);
                    stall_len.push_back(gold[i+2]);
                end
                3: begin
                    exp_addr.push_back(gold[i+2][7:0]);
                    exp_data.push_back(gold[i+3]);
                end
                default: ;
            endcase
        end
        golden_loaded = 1'b1;

        // registers are unknown until the first reset edge.
        for (int i = 1; i <= 11; i++) begin
            @(posedge clk);
            if (i >= 2) begin
                check_eq(T_RESET, "ctrl_rdy", 64'(ctrl_rdy), 64'(0));
                check_eq(T_RESET, "ctrl_ack", 64'(ctrl_ack), 64'(0));
            end
            if (i == 10) begin
                reset <= 1'b0;
            end
        end
        report_test(T_RESET);

        while (drivers_done < N) @(posedge clk);
        while (inflight != 0) @(posedge clk);
        @(posedge clk);

        for (int i = 0; i < exp_addr.size(); i++) begin
            rd_addr <= exp_addr[i];
            repeat (2) @(posedge clk);
            check_eq(T_DATA, $sformatf("rd_data @%02h", exp_addr[i]),
                     64'(rd_data), 64'(exp_data[i]));
        end

        total_acc = 0;
        for (int c = 0; c < N; c++) begin
            check_eq(T_ACK, $sformatf("acks[%0d]", c), 64'(acks[c]), 64'(accepts[c]));
            check_eq(T_STALL, $sformatf("accepts[%0d]", c),
                     64'(accepts[c]), 64'(wr_q[c].size()));
            total_acc += accepts[c];
        end

        for (int t = T_ACK; t <= T_INFLIGHT; t++) begin
            report_test(t);
        end
        total_errs = 0;
        for (int t = 0; t < 6; t++) begin
            total_errs += errs[t];
        end
        $display("summary: %0d checks, %0d errors, %0d writes accepted",
                 n_checks, total_errs, total_acc);
        if (total_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : mem_wr_subsys_tb

`default_nettype wire

// ==== testbench/mem_wr_golden.txt ====
// kind 1 write: controller, address, data. kind 2 stall: start cycle, length, unused.
// kind 3 expected word: unused, address, data. all fields hex, four per line.
1 0 10 a0000010
1 0 11 a0000011
1 0 12 a0000012
1 0 13 a0000013
1 0 14 a0000014
1 0 13 a00000ff
1 1 40 b1000040
1 1 41 b1000041
1 1 42 b1000042
1 1 43 b1000043
1 1 44 b1000044
1 2 80 c2000080
1 2 81 c2000081
1 2 82 c2000082
1 2 83 c2000083
2 8 6 0
2 1e 5 0
3 0 10 a0000010
3 0 11 a0000011
3 0 12 a0000012
3 0 13 a00000ff
3 0 14 a0000014
3 0 40 b1000040
3 0 41 b1000041
3 0 42 b1000042
3 0 43 b1000043
3 0 44 b1000044
3 0 80 c2000080
3 0 81 c2000081
3 0 82 c2000082
3 0 83 c2000083

// ==== flist.f ====
common/mem_wr_pkg.sv
common/mem_wr_arb_pkg.sv
mem_wr_mux/mem_wr_ctxt_fifo.sv
mem_wr_mux/mem_wr_mux.sv
verilog/mem_wr_arbiter.sv
verilog/burst_counter.sv
verilog/mem_wr_ram.sv
verilog/mem_wr_subsys.sv
testbench/mem_wr_subsys_properties.sv
testbench/mem_wr_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports the result in the exit status.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module mem_wr_subsys_tb -f flist.f -o mem_wr_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/mem_wr_sim 2>&1); then
    echo "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi

echo "$sim_out"

if grep -q "^Simulation finished: PASS$" <<< "$sim_out"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1
